//--- src/cpuPkg.sv
`default_nettype none

package cpuPkg;

    localparam int dataWidth = 32;
    localparam int regAddrWidth = 5;
    localparam int imemAddrWidth = 8;
    localparam int dmemAddrWidth = 8;
    localparam int aluOpWidth = 3;

    // Primary opcodes
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opAddiu = 6'h09;
    localparam logic [5:0] opOri = 6'h0d;
    localparam logic [5:0] opLw = 6'h23;
    localparam logic [5:0] opSw = 6'h2b;
    localparam logic [5:0] opBeq = 6'h04;
    localparam logic [5:0] opBne = 6'h05;

    // Function field of opSpecial
    localparam logic [5:0] functAddu = 6'h21;
    localparam logic [5:0] functSubu = 6'h23;
    localparam logic [5:0] functAnd = 6'h24;
    localparam logic [5:0] functOr = 6'h25;
    localparam logic [5:0] functSlt = 6'h2a;

    localparam logic [aluOpWidth-1:0] aluAdd = 3'd0;
    localparam logic [aluOpWidth-1:0] aluSub = 3'd1;
    localparam logic [aluOpWidth-1:0] aluAnd = 3'd2;
    localparam logic [aluOpWidth-1:0] aluOr = 3'd3;
    localparam logic [aluOpWidth-1:0] aluSlt = 3'd4;

    typedef struct packed {
        logic [5:0] opcode;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [regAddrWidth-1:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } regFormat;

    typedef struct packed {
        logic [5:0] opcode;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [15:0] immediate;
    } immFormat;

    // Same word seen as R-type or I-type
    typedef union packed {
        regFormat r;
        immFormat i;
    } instrWord;

endpackage

`default_nettype wire

//--- src/fetchStage.sv
`timescale 1ns/1ns
`default_nettype none

module fetchStage import cpuPkg::*; (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic progWrite,
    input  wire logic [imemAddrWidth-1:0] progAddress,
    input  wire instrWord progData,
    input  wire logic stall,
    input  wire logic redirect,
    input  wire logic [dataWidth-1:0] redirectTarget,
    output logic decodeValid,
    output logic [dataWidth-1:0] decodePc,
    output instrWord decodeInstr
);

    instrWord programMemory [2**imemAddrWidth];
    logic [dataWidth-1:0] pc;
    instrWord fetchInstr;

    always_ff @(posedge clk) begin
        if (progWrite) begin
            programMemory[progAddress] <= progData;
        end
    end

    assign fetchInstr = programMemory[pc[imemAddrWidth+1:2]];

    // Redirect wins; the word fetched alongside it is the delay slot
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
            decodeValid <= 1'b0;
        end
        else if (redirect) begin
            pc <= redirectTarget;
            decodeValid <= 1'b1;
        end
        else if (!stall) begin
            pc <= pc + 32'd4;
            decodeValid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            decodePc <= pc;
            decodeInstr <= fetchInstr;
        end
    end

    pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- src/registerFile.sv
`timescale 1ns/1ns
`default_nettype none

module registerFile import cpuPkg::*; (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic [regAddrWidth-1:0] readAddressA,
    input  wire logic [regAddrWidth-1:0] readAddressB,
    input  wire logic writeEnable,
    input  wire logic [regAddrWidth-1:0] writeAddress,
    input  wire logic [dataWidth-1:0] writeData,
    output logic [dataWidth-1:0] readDataA,
    output logic [dataWidth-1:0] readDataB
);

    logic [dataWidth-1:0] regs [2**regAddrWidth];
    logic writeLive;

    assign writeLive = writeEnable && writeAddress != '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**regAddrWidth; i++) begin
                regs[i] <= '0;
            end
        end
        else if (writeLive) begin
            regs[writeAddress] <= writeData;
        end
    end

    // Same-cycle write shows up on the read ports
    assign readDataA = (readAddressA == '0) ? '0 :
        (writeLive && writeAddress == readAddressA) ? writeData : regs[readAddressA];
    assign readDataB = (readAddressB == '0) ? '0 :
        (writeLive && writeAddress == readAddressB) ? writeData : regs[readAddressB];

    // Writeback never aims a write at register zero
    zeroRegister: assert property (@(posedge clk) disable iff (reset)
        writeEnable |-> writeAddress != '0);

endmodule

`default_nettype wire

//--- src/decodeStage.sv
`timescale 1ns/1ns
`default_nettype none

module decodeStage import cpuPkg::*; (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic decodeValid,
    input  wire logic [dataWidth-1:0] decodePc,
    input  wire instrWord decodeInstr,
    input  wire logic [dataWidth-1:0] readDataA,
    input  wire logic [dataWidth-1:0] readDataB,
    input  wire logic memRegWrite,
    input  wire logic memRead,
    input  wire logic [regAddrWidth-1:0] memDest,
    input  wire logic [dataWidth-1:0] memAluResult,
    input  wire logic wbRegWrite,
    input  wire logic [regAddrWidth-1:0] wbDest,
    input  wire logic [dataWidth-1:0] wbData,
    output logic [regAddrWidth-1:0] readAddressA,
    output logic [regAddrWidth-1:0] readAddressB,
    output logic stall,
    output logic redirect,
    output logic [dataWidth-1:0] redirectTarget,
    output logic exValid,
    output logic [aluOpWidth-1:0] exAluOp,
    output logic exUseImm,
    output logic exRegWrite,
    output logic exMemRead,
    output logic exMemWrite,
    output logic [dataWidth-1:0] exPc,
    output logic [dataWidth-1:0] exOperandA,
    output logic [dataWidth-1:0] exOperandB,
    output logic [dataWidth-1:0] exImmediate,
    output logic [regAddrWidth-1:0] exRs,
    output logic [regAddrWidth-1:0] exRt,
    output logic [regAddrWidth-1:0] exDest
);

    logic [5:0] opcode;
    logic [regAddrWidth-1:0] rs;
    logic [regAddrWidth-1:0] rt;
    logic [dataWidth-1:0] immSigned;
    logic [dataWidth-1:0] immediate;
    logic [regAddrWidth-1:0] dest;
    logic [aluOpWidth-1:0] aluOp;
    logic useImm;
    logic writesReg;
    logic isLoad;
    logic isStore;
    logic isBranch;
    logic usesRt;
    logic zeroExtend;
    logic [dataWidth-1:0] operandA;
    logic [dataWidth-1:0] operandB;
    logic branchTaken;
    logic loadUseHazard;
    logic branchHazard;
    logic issue;

    function automatic logic [dataWidth-1:0] forwardOperand(
        input logic [regAddrWidth-1:0] address,
        input logic [dataWidth-1:0] fileValue
    );
        if (address != '0 && memRegWrite && !memRead && memDest == address) begin
            return memAluResult;
        end
        else if (address != '0 && wbRegWrite && wbDest == address) begin
            return wbData;
        end
        return fileValue;
    endfunction

    assign opcode = decodeInstr.r.opcode;
    assign rs = decodeInstr.r.rs;
    assign rt = decodeInstr.r.rt;
    assign immSigned = {{16{decodeInstr.i.immediate[15]}}, decodeInstr.i.immediate};
    assign immediate = zeroExtend ? {16'h0000, decodeInstr.i.immediate} : immSigned;
    assign readAddressA = rs;
    assign readAddressB = rt;

    always_comb begin
        aluOp = aluAdd;
        useImm = 1'b0;
        writesReg = 1'b0;
        isLoad = 1'b0;
        isStore = 1'b0;
        isBranch = 1'b0;
        usesRt = 1'b0;
        zeroExtend = 1'b0;
        dest = rt;
        case (opcode)
            opSpecial: begin
                dest = decodeInstr.r.rd;
                usesRt = 1'b1;
                writesReg = 1'b1;
                case (decodeInstr.r.funct)
                    functAddu: aluOp = aluAdd;
                    functSubu: aluOp = aluSub;
                    functAnd: aluOp = aluAnd;
                    functOr: aluOp = aluOr;
                    functSlt: aluOp = aluSlt;
                    default: writesReg = 1'b0;
                endcase
            end
            opAddiu: begin
                useImm = 1'b1;
                writesReg = 1'b1;
            end
            opOri: begin
                aluOp = aluOr;
                useImm = 1'b1;
                writesReg = 1'b1;
                zeroExtend = 1'b1;
            end
            opLw: begin
                useImm = 1'b1;
                writesReg = 1'b1;
                isLoad = 1'b1;
            end
            opSw: begin
                useImm = 1'b1;
                usesRt = 1'b1;
                isStore = 1'b1;
            end
            opBeq, opBne: begin
                usesRt = 1'b1;
                isBranch = 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign operandA = forwardOperand(rs, readDataA);
    assign operandB = forwardOperand(rt, readDataB);
    assign branchTaken = (opcode == opBeq) ? (operandA == operandB) : (operandA != operandB);

    // Values still on their way from a load, or not yet out of the ALU for a branch
    assign loadUseHazard = exMemRead && exDest != '0 &&
        (exDest == rs || (usesRt && exDest == rt));
    assign branchHazard = isBranch &&
        ((exRegWrite && (exDest == rs || exDest == rt)) ||
         (memRegWrite && memRead && (memDest == rs || memDest == rt)));

    assign stall = decodeValid && (loadUseHazard || branchHazard);
    assign redirect = decodeValid && isBranch && branchTaken && !stall;
    assign redirectTarget = decodePc + 32'd4 + {immSigned[dataWidth-3:0], 2'b00};
    assign issue = decodeValid && !stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            exValid <= 1'b0;
            exRegWrite <= 1'b0;
            exMemRead <= 1'b0;
            exMemWrite <= 1'b0;
        end
        else begin
            exValid <= issue;
            exRegWrite <= issue && writesReg && dest != '0;
            exMemRead <= issue && isLoad;
            exMemWrite <= issue && isStore;
        end
    end

    always_ff @(posedge clk) begin
        exAluOp <= aluOp;
        exUseImm <= useImm;
        exPc <= decodePc;
        exOperandA <= operandA;
        exOperandB <= operandB;
        exImmediate <= immediate;
        exRs <= rs;
        exRt <= rt;
        exDest <= dest;
    end

    // A branch behind a load waits longest, two cycles
    stallBounded: assert property (@(posedge clk) disable iff (reset)
        stall && $past(stall) |=> !stall);

endmodule

`default_nettype wire

//--- src/executeStage.sv
`timescale 1ns/1ns
`default_nettype none

module executeStage import cpuPkg::*; (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic exValid,
    input  wire logic [aluOpWidth-1:0] exAluOp,
    input  wire logic exUseImm,
    input  wire logic exRegWrite,
    input  wire logic exMemRead,
    input  wire logic exMemWrite,
    input  wire logic [dataWidth-1:0] exPc,
    input  wire logic [dataWidth-1:0] exOperandA,
    input  wire logic [dataWidth-1:0] exOperandB,
    input  wire logic [dataWidth-1:0] exImmediate,
    input  wire logic [regAddrWidth-1:0] exRs,
    input  wire logic [regAddrWidth-1:0] exRt,
    input  wire logic [regAddrWidth-1:0] exDest,
    input  wire logic wbRegWrite,
    input  wire logic [regAddrWidth-1:0] wbDest,
    input  wire logic [dataWidth-1:0] wbData,
    output logic memValid,
    output logic memRegWrite,
    output logic memRead,
    output logic memWrite,
    output logic [dataWidth-1:0] memPc,
    output logic [dataWidth-1:0] memAluResult,
    output logic [dataWidth-1:0] memStoreData,
    output logic [regAddrWidth-1:0] memDest
);

    logic [dataWidth-1:0] valueA;
    logic [dataWidth-1:0] valueB;
    logic [dataWidth-1:0] aluB;
    logic [dataWidth-1:0] aluResult;

    // Newest producer first
    function automatic logic [dataWidth-1:0] forwardOperand(
        input logic [regAddrWidth-1:0] address,
        input logic [dataWidth-1:0] staleValue
    );
        if (address != '0 && memRegWrite && !memRead && memDest == address) begin
            return memAluResult;
        end
        else if (address != '0 && wbRegWrite && wbDest == address) begin
            return wbData;
        end
        return staleValue;
    endfunction

    assign valueA = forwardOperand(exRs, exOperandA);
    assign valueB = forwardOperand(exRt, exOperandB);
    assign aluB = exUseImm ? exImmediate : valueB;

    always_comb begin
        case (exAluOp)
            aluAdd: aluResult = valueA + aluB;
            aluSub: aluResult = valueA - aluB;
            aluAnd: aluResult = valueA & aluB;
            aluOr: aluResult = valueA | aluB;
            aluSlt: aluResult = {31'd0, $signed(valueA) < $signed(aluB)};
            default: aluResult = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            memValid <= 1'b0;
            memRegWrite <= 1'b0;
            memRead <= 1'b0;
            memWrite <= 1'b0;
        end
        else begin
            memValid <= exValid;
            memRegWrite <= exRegWrite;
            memRead <= exMemRead;
            memWrite <= exMemWrite;
        end
    end

    always_ff @(posedge clk) begin
        memPc <= exPc;
        memAluResult <= aluResult;
        memStoreData <= valueB;
        memDest <= exDest;
    end

endmodule

`default_nettype wire

//--- src/memoryStage.sv
`timescale 1ns/1ns
`default_nettype none

module memoryStage import cpuPkg::*; (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic memValid,
    input  wire logic memRegWrite,
    input  wire logic memRead,
    input  wire logic memWrite,
    input  wire logic [dataWidth-1:0] memPc,
    input  wire logic [dataWidth-1:0] memAluResult,
    input  wire logic [dataWidth-1:0] memStoreData,
    input  wire logic [regAddrWidth-1:0] memDest,
    output logic wbRegWrite,
    output logic [regAddrWidth-1:0] wbDest,
    output logic [dataWidth-1:0] wbData,
    output logic retireValid,
    output logic [dataWidth-1:0] retirePc,
    output logic regWrite,
    output logic [regAddrWidth-1:0] regWriteAddress,
    output logic [dataWidth-1:0] regWriteData
);

    logic [dataWidth-1:0] dataMemory [2**dmemAddrWidth];
    logic [dmemAddrWidth-1:0] wordIndex;
    logic [dataWidth-1:0] loadData;
    logic wbValid;
    logic [dataWidth-1:0] wbPc;

    assign wordIndex = memAluResult[dmemAddrWidth+1:2];
    assign loadData = dataMemory[wordIndex];

    always_ff @(posedge clk) begin
        if (memWrite) begin
            dataMemory[wordIndex] <= memStoreData;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wbValid <= 1'b0;
            wbRegWrite <= 1'b0;
        end
        else begin
            wbValid <= memValid;
            wbRegWrite <= memRegWrite;
        end
    end

    always_ff @(posedge clk) begin
        wbPc <= memPc;
        wbDest <= memDest;
        wbData <= memRead ? loadData : memAluResult;
    end

    // Commit report
    assign retireValid = wbValid;
    assign retirePc = wbPc;
    assign regWrite = wbRegWrite;
    assign regWriteAddress = wbDest;
    assign regWriteData = wbData;

    accessAligned: assert property (@(posedge clk) disable iff (reset)
        (memRead || memWrite) |-> memAluResult[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- src/pipelineCpu.sv
`timescale 1ns/1ns
`default_nettype none

module pipelineCpu import cpuPkg::*; (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic progWrite,
    input  wire logic [imemAddrWidth-1:0] progAddress,
    input  wire instrWord progData,
    output logic retireValid,
    output logic [dataWidth-1:0] retirePc,
    output logic regWrite,
    output logic [regAddrWidth-1:0] regWriteAddress,
    output logic [dataWidth-1:0] regWriteData
);

    logic decodeValid;
    logic [dataWidth-1:0] decodePc;
    instrWord decodeInstr;
    logic stall;
    logic redirect;
    logic [dataWidth-1:0] redirectTarget;
    logic [regAddrWidth-1:0] readAddressA;
    logic [regAddrWidth-1:0] readAddressB;
    logic [dataWidth-1:0] readDataA;
    logic [dataWidth-1:0] readDataB;

    logic exValid;
    logic [aluOpWidth-1:0] exAluOp;
    logic exUseImm;
    logic exRegWrite;
    logic exMemRead;
    logic exMemWrite;
    logic [dataWidth-1:0] exPc;
    logic [dataWidth-1:0] exOperandA;
    logic [dataWidth-1:0] exOperandB;
    logic [dataWidth-1:0] exImmediate;
    logic [regAddrWidth-1:0] exRs;
    logic [regAddrWidth-1:0] exRt;
    logic [regAddrWidth-1:0] exDest;

    logic memValid;
    logic memRegWrite;
    logic memRead;
    logic memWrite;
    logic [dataWidth-1:0] memPc;
    logic [dataWidth-1:0] memAluResult;
    logic [dataWidth-1:0] memStoreData;
    logic [regAddrWidth-1:0] memDest;

    logic wbRegWrite;
    logic [regAddrWidth-1:0] wbDest;
    logic [dataWidth-1:0] wbData;

    fetchStage fetchStage_i (.*);

    decodeStage decodeStage_i (.*);

    // Writeback drives the register file write port
    registerFile registerFile_i (
        .clk(clk),
        .reset(reset),
        .readAddressA(readAddressA),
        .readAddressB(readAddressB),
        .writeEnable(wbRegWrite),
        .writeAddress(wbDest),
        .writeData(wbData),
        .readDataA(readDataA),
        .readDataB(readDataB)
    );

    executeStage executeStage_i (.*);

    memoryStage memoryStage_i (.*);

endmodule

`default_nettype wire

//--- dv/cpuTests.svh
`ifndef cpuTestsSvh
`define cpuTestsSvh

// Back-to-back dependent ALU chain with random registers and immediates
task automatic testForwarding();
    logic [regAddrWidth-1:0] a;
    logic [regAddrWidth-1:0] b;
    logic [regAddrWidth-1:0] c;
    startProgram();
    for (int round = 0; round < 3; round++) begin
        a = pickReg();
        b = pickReg();
        c = pickReg();
        emitI(opAddiu, a, 5'd0, pickImm());
        emitI(opAddiu, b, a, pickImm());
        emitR(functAddu, c, a, b);
        emitR(functSubu, a, c, b);
        emitR(functAnd, b, a, c);
        emitR(functOr, c, b, a);
        emitR(functSlt, a, c, b);
        emitI(opOri, a, b, pickImm());
        emitR(functAddu, c, b, a);
        emitI(opAddiu, c, c, pickImm());
        emitR(functSlt, b, a, c);
    end
    runProgram("forwarding");
endtask

task automatic testLoadUse();
    startProgram();
    emitI(opAddiu, 5'd1, 5'd0, 16'h0040);
    emitI(opAddiu, 5'd2, 5'd0, pickImm());
    emitI(opSw, 5'd2, 5'd1, 16'h0008);
    emitI(opLw, 5'd3, 5'd1, 16'h0008);
    // Loaded value needed at once on rs and then on rt
    emitR(functAddu, 5'd4, 5'd3, 5'd2);
    emitI(opLw, 5'd5, 5'd1, 16'h0008);
    emitR(functSubu, 5'd6, 5'd2, 5'd5);
    emitI(opLw, 5'd7, 5'd1, 16'h0008);
    emitI(opSw, 5'd7, 5'd1, 16'h000c);
    emitI(opLw, 5'd8, 5'd1, 16'h000c);
    emitI(opAddiu, 5'd9, 5'd8, 16'h0001);
    emitR(functOr, 5'd10, 5'd9, 5'd4);
    runProgram("load-use stall");
endtask

task automatic testTakenBranches();
    startProgram();
    emitI(opAddiu, 5'd1, 5'd0, 16'h0005);
    emitI(opAddiu, 5'd2, 5'd0, 16'h0005);
    emitBranch(opBeq, 5'd1, 5'd2, 2);
    emitI(opAddiu, 5'd3, 5'd0, 16'h0001);
    emitI(opAddiu, 5'd4, 5'd0, 16'h0063);
    emitI(opAddiu, 5'd5, 5'd0, 16'h0007);
    emitBranch(opBne, 5'd5, 5'd1, 3);
    emitR(functAddu, 5'd6, 5'd5, 5'd1);
    emitI(opAddiu, 5'd7, 5'd0, 16'h0001);
    emitI(opAddiu, 5'd8, 5'd0, 16'h0002);
    emitI(opOri, 5'd9, 5'd6, 16'h00f0);
    // Backward loop with three passes through its delay slot
    emitI(opAddiu, 5'd10, 5'd0, 16'h0003);
    emitI(opAddiu, 5'd10, 5'd10, 16'hffff);
    emitBranch(opBne, 5'd10, 5'd0, -2);
    emitI(opAddiu, 5'd11, 5'd11, 16'h0001);
    emitR(functOr, 5'd12, 5'd11, 5'd10);
    runProgram("taken branches");
endtask

task automatic testNotTakenAfterResult();
    startProgram();
    emitI(opAddiu, 5'd1, 5'd0, pickImm());
    emitI(opAddiu, 5'd2, 5'd1, 16'h0001);
    emitBranch(opBeq, 5'd2, 5'd1, 4);
    emitR(functAddu, 5'd3, 5'd2, 5'd1);
    emitI(opAddiu, 5'd4, 5'd0, 16'h0080);
    emitI(opSw, 5'd2, 5'd4, 16'h0000);
    emitI(opLw, 5'd5, 5'd4, 16'h0000);
    // Operand comes straight from the load
    emitBranch(opBne, 5'd5, 5'd2, 3);
    emitR(functSubu, 5'd6, 5'd5, 5'd1);
    emitBranch(opBeq, 5'd6, 5'd0, 2);
    emitR(functOr, 5'd7, 5'd6, 5'd5);
    emitR(functSlt, 5'd8, 5'd1, 5'd2);
    emitI(opAddiu, 5'd9, 5'd8, 16'h0000);
    runProgram("not-taken branches");
endtask

task automatic testZeroRegister();
    startProgram();
    emitI(opAddiu, 5'd0, 5'd0, 16'h1234);
    emitR(functAddu, 5'd1, 5'd0, 5'd0);
    emitI(opOri, 5'd0, 5'd0, 16'hffff);
    emitR(functOr, 5'd2, 5'd0, 5'd0);
    programWords.push_back('0);
    emitI(opAddiu, 5'd3, 5'd0, pickImm());
    emitR(functAddu, 5'd0, 5'd3, 5'd3);
    emitR(functAddu, 5'd4, 5'd0, 5'd3);
    emitI(opSw, 5'd3, 5'd0, 16'h0100);
    emitI(opLw, 5'd0, 5'd0, 16'h0100);
    emitR(functAddu, 5'd5, 5'd0, 5'd3);
    runProgram("register zero");
endtask

`endif

//--- dv/cpuTb.sv
`timescale 1ns/1ns
`default_nettype none

module cpuTb import cpuPkg::*; ();

    localparam int resetCycles = 10;
    localparam int retireTimeout = 20;
    localparam int padNops = 8;
    localparam int modelStepLimit = 500;
    localparam int unsigned randomSeed = 32'he0fc;

    logic clk;
    logic reset;
    logic progWrite;
    logic [imemAddrWidth-1:0] progAddress;
    instrWord progData;
    logic retireValid;
    logic [dataWidth-1:0] retirePc;
    logic regWrite;
    logic [regAddrWidth-1:0] regWriteAddress;
    logic [dataWidth-1:0] regWriteData;

    // Program under test and the expected commit stream
    instrWord programWords[$];
    logic [dataWidth-1:0] expPc[$];
    logic expWrite[$];
    logic [regAddrWidth-1:0] expAddress[$];
    logic [dataWidth-1:0] expData[$];
    logic [dataWidth-1:0] modelRegs [32];
    logic [dataWidth-1:0] modelMemory [logic [dataWidth-1:0]];

    pipelineCpu pipelineCpu_i (.*);

    always #10 clk = ~clk;

    task automatic abortRun();
        $display("Test failures found");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic checkPc(input string name, input logic [dataWidth-1:0] actual,
                           input logic [dataWidth-1:0] expected);
        if (actual !== expected) begin
            $display("Error: %s is 0x%h, expected 0x%h", name, actual, expected);
            abortRun();
        end
    endtask

    task automatic checkRegAddress(input string name, input logic [regAddrWidth-1:0] actual,
                                   input logic [regAddrWidth-1:0] expected);
        if (actual !== expected) begin
            $display("Error: %s is 0x%h, expected 0x%h", name, actual, expected);
            abortRun();
        end
    endtask

    task automatic checkData(input string name, input logic [dataWidth-1:0] actual,
                             input logic [dataWidth-1:0] expected);
        if (actual !== expected) begin
            $display("Error: %s is 0x%h, expected 0x%h", name, actual, expected);
            abortRun();
        end
    endtask

    task automatic checkFlag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("Error: %s is 0x%h, expected 0x%h", name, actual, expected);
            abortRun();
        end
    endtask

    function automatic instrWord encodeR(input logic [5:0] funct,
                                         input logic [regAddrWidth-1:0] rd,
                                         input logic [regAddrWidth-1:0] rs,
                                         input logic [regAddrWidth-1:0] rt);
        instrWord word;
        word.r.opcode = opSpecial;
        word.r.rs = rs;
        word.r.rt = rt;
        word.r.rd = rd;
        word.r.shamt = '0;
        word.r.funct = funct;
        return word;
    endfunction

    function automatic instrWord encodeI(input logic [5:0] opcode,
                                         input logic [regAddrWidth-1:0] rs,
                                         input logic [regAddrWidth-1:0] rt,
                                         input logic [15:0] immediate);
        instrWord word;
        word.i.opcode = opcode;
        word.i.rs = rs;
        word.i.rt = rt;
        word.i.immediate = immediate;
        return word;
    endfunction

    // Operands in assembler order rd, rs, rt
    task automatic emitR(input logic [5:0] funct, input logic [regAddrWidth-1:0] rd,
                         input logic [regAddrWidth-1:0] rs, input logic [regAddrWidth-1:0] rt);
        programWords.push_back(encodeR(funct, rd, rs, rt));
    endtask

    // Operands in assembler order rt, rs, immediate
    task automatic emitI(input logic [5:0] opcode, input logic [regAddrWidth-1:0] rt,
                         input logic [regAddrWidth-1:0] rs, input logic [15:0] immediate);
        programWords.push_back(encodeI(opcode, rs, rt, immediate));
    endtask

    // Offset counts words from the delay slot
    task automatic emitBranch(input logic [5:0] opcode, input logic [regAddrWidth-1:0] rs,
                              input logic [regAddrWidth-1:0] rt, input int offset);
        programWords.push_back(encodeI(opcode, rs, rt, 16'(offset)));
    endtask

    function automatic logic [regAddrWidth-1:0] pickReg();
        return regAddrWidth'($urandom_range(31, 1));
    endfunction

    function automatic logic [15:0] pickImm();
        return 16'($urandom());
    endfunction

    task automatic startProgram();
        programWords.delete();
        expPc.delete();
        expWrite.delete();
        expAddress.delete();
        expData.delete();
    endtask

    // Sequential ISA model; the word after a branch always runs
    task automatic runModel();
        instrWord word;
        logic [dataWidth-1:0] pc;
        logic [dataWidth-1:0] nextPc;
        logic [dataWidth-1:0] target;
        logic [dataWidth-1:0] valueA;
        logic [dataWidth-1:0] valueB;
        logic [dataWidth-1:0] immSigned;
        logic [dataWidth-1:0] result;
        logic [dataWidth-1:0] address;
        logic [regAddrWidth-1:0] dest;
        logic writes;
        logic branchNow;
        logic branchPending;
        int index;
        int steps;
        for (int r = 0; r < 32; r++) begin
            modelRegs[r] = '0;
        end
        modelMemory.delete();
        pc = '0;
        target = '0;
        branchPending = 1'b0;
        index = 0;
        steps = 0;
        while (index < programWords.size()) begin
            word = programWords[index];
            immSigned = {{16{word.i.immediate[15]}}, word.i.immediate};
            valueA = modelRegs[word.r.rs];
            valueB = modelRegs[word.r.rt];
            writes = 1'b0;
            dest = word.i.rt;
            result = '0;
            branchNow = 1'b0;
            case (word.r.opcode)
                opSpecial: begin
                    dest = word.r.rd;
                    writes = 1'b1;
                    case (word.r.funct)
                        functAddu: result = valueA + valueB;
                        functSubu: result = valueA - valueB;
                        functAnd: result = valueA & valueB;
                        functOr: result = valueA | valueB;
                        functSlt: result = ($signed(valueA) < $signed(valueB)) ? 32'd1 : 32'd0;
                        default: writes = 1'b0;
                    endcase
                end
                opAddiu: begin
                    writes = 1'b1;
                    result = valueA + immSigned;
                end
                opOri: begin
                    writes = 1'b1;
                    result = valueA | {16'h0000, word.i.immediate};
                end
                opLw: begin
                    address = valueA + immSigned;
                    if (!modelMemory.exists(address)) begin
                        $display("Reference model loads 0x%h, which was never stored", address);
                        abortRun();
                    end
                    writes = 1'b1;
                    result = modelMemory[address];
                end
                opSw: begin
                    address = valueA + immSigned;
                    modelMemory[address] = valueB;
                end
                opBeq: branchNow = (valueA == valueB);
                opBne: branchNow = (valueA != valueB);
                default: begin
                end
            endcase
            if (writes && dest != '0) begin
                modelRegs[dest] = result;
            end
            expPc.push_back(pc);
            expWrite.push_back(writes && dest != '0);
            expAddress.push_back(dest);
            expData.push_back(result);
            nextPc = branchPending ? target : pc + 32'd4;
            branchPending = branchNow;
            if (branchNow) begin
                target = pc + 32'd4 + (immSigned << 2);
            end
            pc = nextPc;
            index = int'(pc >> 2);
            steps++;
            if (steps > modelStepLimit) begin
                $display("Reference model never reached the end of the program");
                abortRun();
            end
        end
    endtask

    // Program loads while reset is held and is padded with nops
    task automatic resetAndLoad();
        int total;
        total = programWords.size() + padNops;
        for (int cycle = 0; cycle < resetCycles || cycle < total; cycle++) begin
            @(negedge clk);
            reset = 1'b1;
            if (cycle > 0) begin
                checkFlag("retireValid", retireValid, 1'b0);
                checkFlag("regWrite", regWrite, 1'b0);
            end
            progWrite = (cycle < total);
            progAddress = cycle[imemAddrWidth-1:0];
            progData = (cycle < programWords.size()) ? programWords[cycle] : '0;
        end
        @(negedge clk);
        progWrite = 1'b0;
        reset = 1'b0;
    endtask

    task automatic collectRetires();
        int waitCycles;
        for (int i = 0; i < expPc.size(); i++) begin
            waitCycles = 0;
            @(negedge clk);
            while (!retireValid) begin
                checkFlag("regWrite", regWrite, 1'b0);
                waitCycles++;
                if (waitCycles > retireTimeout) begin
                    $display("Timeout: retire %0d at pc 0x%h never came", i, expPc[i]);
                    abortRun();
                end
                @(negedge clk);
            end
            checkPc("retirePc", retirePc, expPc[i]);
            checkFlag("regWrite", regWrite, expWrite[i]);
            if (expWrite[i]) begin
                checkRegAddress("regWriteAddress", regWriteAddress, expAddress[i]);
                checkData("regWriteData", regWriteData, expData[i]);
            end
        end
    endtask

    task automatic runProgram(input string name);
        runModel();
        resetAndLoad();
        collectRetires();
        $display("%s: %0d commits matched", name, expPc.size());
    endtask

    `include "cpuTests.svh"

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        progWrite = 1'b0;
        progAddress = '0;
        progData = '0;
        void'($urandom(randomSeed));
        testForwarding();
        testLoadUse();
        testTakenBranches();
        testNotTakenAfterResult();
        testZeroRegister();
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+dv
src/cpuPkg.sv
src/fetchStage.sv
src/registerFile.sv
src/decodeStage.sv
src/executeStage.sv
src/memoryStage.sv
src/pipelineCpu.sv
dv/cpuTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= cpuTb
OBJ_DIR ?= obj_dir
FILELIST ?= sim.f
VERILATOR_FLAGS ?= --binary --timing --assert -j 0

SOURCES := $(wildcard src/*.sv) $(wildcard dv/*.sv) $(wildcard dv/*.svh)
BINARY := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BINARY)
	$(BINARY)

clean:
	rm -rf $(OBJ_DIR)
